//--- design/dl_settings.svh
// Memory map and widths for the ROM download post-processor.
// Included by the package and by every module that sizes a port or
// compares a loader address against a region boundary.

`ifndef DL_SETTINGS_SVH
`define DL_SETTINGS_SVH

// Loader byte address, SDRAM word address, PROM write address
`define DL_ADDR_W     25
`define DL_WADDR_W    22
`define DL_PROM_AW    11

// Ascending region starts as byte offsets into the image
// Everything below the sound start is main CPU code
`define DL_SND_START  25'h001_0000
`define DL_SCR_START  25'h001_2000
`define DL_OBJ_START  25'h001_6000
`define DL_PCM_START  25'h001_E000
`define DL_PROM_START 25'h002_2000

// First byte past the image
// Anything at or above it is dropped
`define DL_END        25'h002_2800

`endif

//--- design/dl_pkg.sv
// Types shared by the download post-processor stages.
// Holds the region code, the word address union and the beat that
// moves down the three-stage pipeline.

`include "dl_settings.svh"

package dl_pkg;

    // Destination of one downloaded byte
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SND,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM,
        REG_NONE
    } dl_region_e;

    // Object tile view of a word address
    // Column and row pick the 8x8 cell inside a 32-word tile group
    typedef struct packed {
        logic [`DL_WADDR_W-6:0] upper;
        logic [1:0]             col;
        logic [2:0]             row;
    } dl_obj_view_s;

    // The same 22 bits read as a plain word or as the object view
    typedef union packed {
        logic [`DL_WADDR_W-1:0] word;
        dl_obj_view_s           obj;
    } dl_waddr_u;

    // One byte in flight between stages
    typedef struct packed {
        logic                   valid;
        dl_region_e             region;
        dl_waddr_u              waddr;
        logic                   lane;      // set for the high byte
        logic [7:0]             data;
        logic [`DL_PROM_AW-1:0] prom_addr;
    } dl_beat_s;

endpackage

//--- design/dl_region_decode.sv
// First pipeline stage of the download post-processor.
// Sorts each loader byte into its ROM region and splits the byte address
// into an SDRAM word address, a byte lane and a PROM-relative address.

`timescale 1ns/1ps

`include "dl_settings.svh"

module dl_region_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ioctl_wr,
    input  logic [`DL_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]            ioctl_dout,
    output dl_pkg::dl_beat_s      beat
);

    dl_pkg::dl_region_e    region;
    logic [`DL_ADDR_W-1:0] prom_off;
    logic [`DL_ADDR_W-2:0] word_full;
    dl_pkg::dl_beat_s      next_beat;

    // Region boundaries checked from the top of the image down
    always_comb begin
        if (ioctl_addr >= `DL_END) begin
            region = dl_pkg::REG_NONE;
        end else if (ioctl_addr >= `DL_PROM_START) begin
            region = dl_pkg::REG_PROM;
        end else if (ioctl_addr >= `DL_PCM_START) begin
            region = dl_pkg::REG_PCM;
        end else if (ioctl_addr >= `DL_OBJ_START) begin
            region = dl_pkg::REG_OBJ;
        end else if (ioctl_addr >= `DL_SCR_START) begin
            region = dl_pkg::REG_SCR;
        end else if (ioctl_addr >= `DL_SND_START) begin
            region = dl_pkg::REG_SND;
        end else begin
            region = dl_pkg::REG_MAIN;
        end
    end

    assign prom_off  = ioctl_addr - `DL_PROM_START;
    assign word_full = ioctl_addr[`DL_ADDR_W-1:1];

    always_comb begin
        next_beat            = '0;
        next_beat.valid      = ioctl_wr;
        next_beat.region     = region;
        // SDRAM words are 16 bits and hold two loader bytes
        next_beat.waddr.word = word_full[`DL_WADDR_W-1:0];
        next_beat.lane       = ioctl_addr[0];
        next_beat.data       = ioctl_dout;
        next_beat.prom_addr  = prom_off[`DL_PROM_AW-1:0];
    end

    // Stage register
    always_ff @(posedge clk) begin
        beat <= next_beat;
        if (rst) begin
            beat.valid <= 1'b0;
        end
    end

endmodule

//--- design/dl_addr_scramble.sv
// Second pipeline stage of the download post-processor.
// Reorders word address bits for the two graphics regions so the tile
// data lands in SDRAM in the order the video fetch logic reads it.

`timescale 1ns/1ps

module dl_addr_scramble (
    input  logic             clk,
    input  logic             rst,
    input  dl_pkg::dl_beat_s beat_in,
    output dl_pkg::dl_beat_s beat_out
);

    dl_pkg::dl_beat_s next_beat;

    always_comb begin
        next_beat = beat_in;
        case (beat_in.region)
            // Scroll tiles swap the two words of each pair
            dl_pkg::REG_SCR: begin
                next_beat.waddr.word[0] = ~beat_in.waddr.word[0];
            end
            // Object tiles move the row up to bits 4..2
            // The column drops to bits 1..0 and is inverted on the way
            dl_pkg::REG_OBJ: begin
                next_beat.waddr.obj.col = beat_in.waddr.obj.row[2:1];
                next_beat.waddr.obj.row = {
                    beat_in.waddr.obj.row[0],
                    ~beat_in.waddr.obj.col
                };
            end
            default: begin
                // Other regions keep the decoded address
            end
        endcase
    end

    always_ff @(posedge clk) begin
        beat_out <= next_beat;
        if (rst) begin
            beat_out.valid <= 1'b0;
        end
    end

endmodule

//--- design/dl_write_port.sv
// Last pipeline stage of the download post-processor.
// Turns a beat into either an SDRAM programming write or a colour PROM
// write. Bytes outside the image give no strobe at all.

`timescale 1ns/1ps

`include "dl_settings.svh"

module dl_write_port (
    input  logic                   clk,
    input  logic                   rst,
    input  dl_pkg::dl_beat_s       beat,
    // SDRAM programming port
    output logic                   prog_we,
    output logic [`DL_WADDR_W-1:0] prog_addr,
    output logic [15:0]            prog_data,
    output logic [1:0]             prog_mask,
    // Colour PROM port
    output logic                   prom_we,
    output logic [`DL_PROM_AW-1:0] prom_addr,
    output logic [7:0]             prom_data
);

    logic to_sdram;
    logic to_prom;

    // MAIN through PCM all live in SDRAM
    always_comb begin
        case (beat.region)
            dl_pkg::REG_MAIN,
            dl_pkg::REG_SND,
            dl_pkg::REG_SCR,
            dl_pkg::REG_OBJ,
            dl_pkg::REG_PCM: begin
                to_sdram = beat.valid;
                to_prom  = 1'b0;
            end
            dl_pkg::REG_PROM: begin
                to_sdram = 1'b0;
                to_prom  = beat.valid;
            end
            default: begin
                to_sdram = 1'b0;
                to_prom  = 1'b0;
            end
        endcase
    end

    // Strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= to_sdram;
            prom_we <= to_prom;
        end
    end

    // Address and data hold between writes
    always_ff @(posedge clk) begin
        if (to_sdram) begin
            prog_addr <= beat.waddr.word;
            // Same byte on both halves and the mask picks the lane
            prog_data <= {beat.data, beat.data};
            prog_mask <= beat.lane ? 2'b10 : 2'b01;
        end
        if (to_prom) begin
            prom_addr <= beat.prom_addr;
            prom_data <= beat.data;
        end
    end

endmodule

//--- design/dl_postproc.sv
// Top level of the ROM download post-processor.
// Chains region decode, graphics address scramble and the write port.
// A byte enters on any cycle and reaches the write ports three clocks later.

`timescale 1ns/1ps

`include "dl_settings.svh"

module dl_postproc (
    input  logic                   clk,
    input  logic                   rst,
    // Loader stream
    input  logic                   ioctl_wr,
    input  logic [`DL_ADDR_W-1:0]  ioctl_addr,
    input  logic [7:0]             ioctl_dout,
    // SDRAM programming
    output logic                   prog_we,
    output logic [`DL_WADDR_W-1:0] prog_addr,
    output logic [15:0]            prog_data,
    output logic [1:0]             prog_mask,
    // Colour PROMs
    output logic                   prom_we,
    output logic [`DL_PROM_AW-1:0] prom_addr,
    output logic [7:0]             prom_data
);

    dl_pkg::dl_beat_s dec_beat;
    dl_pkg::dl_beat_s scr_beat;

    dl_region_decode u_decode (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .beat       ( dec_beat   )
    );

    dl_addr_scramble u_scramble (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .beat_in  ( dec_beat ),
        .beat_out ( scr_beat )
    );

    dl_write_port u_write (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .beat      ( scr_beat  ),
        .prog_we   ( prog_we   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_mask ( prog_mask ),
        .prom_we   ( prom_we   ),
        .prom_addr ( prom_addr ),
        .prom_data ( prom_data )
    );

endmodule

//--- verif/dl_postproc_checker.sv
// Assertions on the write strobes of the download post-processor.
// Bound to dl_postproc from the testbench and watches the top-level outputs.

`timescale 1ns/1ps

module dl_postproc_checker (
    input logic       clk,
    input logic       rst,
    input logic       prog_we,
    input logic       prom_we,
    input logic [1:0] prog_mask
);

    // One beat goes to SDRAM or to the PROMs, never both
    strobe_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(prog_we && prom_we)
    ) else begin
        $error("prog_we and prom_we are high in the same cycle");
    end

    // Exactly one byte lane per SDRAM write
    mask_onehot: assert property (
        @(posedge clk) disable iff (rst)
        prog_we |-> $onehot(prog_mask)
    ) else begin
        $error("prog_mask is not one-hot during an SDRAM write");
    end

    // Strobes clear on the first edge that sees rst
    strobes_low_in_reset: assert property (
        @(posedge clk)
        rst |=> (!prog_we && !prom_we)
    ) else begin
        $error("write strobe high while rst is asserted");
    end

endmodule

//--- verif/dl_postproc_tb.sv
// Directed testbench for the ROM download post-processor.
// Streams loader bytes into dl_postproc, predicts each write from the
// memory map and compares every output strobe in order with latency 3.

`timescale 1ns/1ps

`include "dl_settings.svh"

module dl_postproc_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int DRAIN_LIMIT = 8;
    // Reset plus the six tests with their drain time
    localparam int TEST_CYCLES     = 16 + 14 + 14 + 38 + 11 + 70 + 48;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2000;

    // Expected outcome of one loader byte
    typedef struct packed {
        logic                   is_prog;
        logic                   is_prom;
        logic [`DL_WADDR_W-1:0] waddr;
        logic [15:0]            data16;
        logic [1:0]             mask;
        logic [`DL_PROM_AW-1:0] prom_addr;
        logic [7:0]             prom_data;
        logic [31:0]            due_cycle;
    } exp_write_s;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   ioctl_wr;
    logic [`DL_ADDR_W-1:0]  ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   prog_we;
    logic [`DL_WADDR_W-1:0] prog_addr;
    logic [15:0]            prog_data;
    logic [1:0]             prog_mask;
    logic                   prom_we;
    logic [`DL_PROM_AW-1:0] prom_addr;
    logic [7:0]             prom_data;

    integer      seed        = 78981;
    logic [31:0] cycle_cnt   = '0;
    string       cur_test    = "init";
    exp_write_s  pending[$];

    // Region boundaries for random addresses
    // The last entry lies past the image
    logic [31:0] bounds [0:7] = '{
        32'd0,
        32'(`DL_SND_START),
        32'(`DL_SCR_START),
        32'(`DL_OBJ_START),
        32'(`DL_PCM_START),
        32'(`DL_PROM_START),
        32'(`DL_END),
        32'(`DL_END) + 32'h1000
    };

    dl_postproc dl_postproc_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .prog_we    ( prog_we    ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prom_we    ( prom_we    ),
        .prom_addr  ( prom_addr  ),
        .prom_data  ( prom_data  )
    );

    bind dl_postproc dl_postproc_checker u_checker (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .prog_we   ( prog_we   ),
        .prom_we   ( prom_we   ),
        .prog_mask ( prog_mask )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(string field, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("mismatch in %s (%s): expected %0h, actual %0h",
                                cur_test, field, expected, actual));
        end
    endtask

    // Memory map and tile reordering rules
    function automatic exp_write_s model_write(logic [`DL_ADDR_W-1:0] addr,
                                               logic [7:0] data);
        exp_write_s             e;
        logic [`DL_ADDR_W-1:0]  prom_off;
        logic [`DL_WADDR_W-1:0] w;
        e        = '0;
        prom_off = addr - `DL_PROM_START;
        w        = addr[`DL_WADDR_W:1];
        if (addr < `DL_PROM_START) begin
            if (addr >= `DL_SCR_START && addr < `DL_OBJ_START) begin
                w[0] = ~w[0];
            end else if (addr >= `DL_OBJ_START && addr < `DL_PCM_START) begin
                // Row up to bits 4..2 and inverted column down to bits 1..0
                w[4:0] = {w[2:0], ~w[4], ~w[3]};
            end
            e.is_prog = 1'b1;
            e.waddr   = w;
            e.data16  = {data, data};
            e.mask    = addr[0] ? 2'b10 : 2'b01;
        end else if (addr < `DL_END) begin
            e.is_prom   = 1'b1;
            e.prom_addr = prom_off[`DL_PROM_AW-1:0];
            e.prom_data = data;
        end
        return e;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [`DL_ADDR_W-1:0] random_addr();
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] full;
        logic [2:0]  idx;
        r    = $random(seed);
        sel  = $random(seed);
        sel  = sel % 32'd7;
        idx  = sel[2:0];
        full = bounds[idx] + r % (bounds[idx + 3'd1] - bounds[idx]);
        return full[`DL_ADDR_W-1:0];
    endfunction

    // Drive one byte for one cycle and queue its expected write
    task automatic send_byte(logic [`DL_ADDR_W-1:0] addr, logic [7:0] data);
        exp_write_s e;
        e           = model_write(addr, data);
        e.due_cycle = cycle_cnt + 32'd3;
        if (e.is_prog || e.is_prom) begin
            pending.push_back(e);
        end
        ioctl_wr   = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = data;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited   = 0;
        ioctl_wr = 1'b0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending.size() != 0) begin
            abort_run($sformatf("writes of test %s did not come out of the pipeline",
                                cur_test));
        end
    endtask

    // Outputs settle at the rising edge and are sampled half a period later
    always @(negedge clk) begin : monitor
        exp_write_s e;
        if (prog_we || prom_we) begin
            if (pending.size() == 0) begin
                abort_run($sformatf("unexpected write strobe in test %s", cur_test));
            end else begin
                e = pending.pop_front();
                check_value("latency", e.due_cycle, cycle_cnt);
                check_value("prog_we", 32'(e.is_prog), 32'(prog_we));
                check_value("prom_we", 32'(e.is_prom), 32'(prom_we));
                if (e.is_prog) begin
                    check_value("prog_addr", 32'(e.waddr), 32'(prog_addr));
                    check_value("prog_data", 32'(e.data16), 32'(prog_data));
                    check_value("prog_mask", 32'(e.mask), 32'(prog_mask));
                end else begin
                    check_value("prom_addr", 32'(e.prom_addr), 32'(prom_addr));
                    check_value("prom_data", 32'(e.prom_data), 32'(prom_data));
                end
            end
        end else if (pending.size() != 0 && pending[0].due_cycle <= cycle_cnt) begin
            abort_run($sformatf("expected write in test %s never appeared", cur_test));
        end
    end

    task automatic test_main_sound();
        cur_test = "main_sound";
        send_byte(25'h000_0010, rand_byte());
        send_byte(25'h000_0011, rand_byte());
        send_byte(25'h000_ABCD, rand_byte());
        send_byte(`DL_SND_START - 25'h1, rand_byte());
        send_byte(`DL_SND_START, rand_byte());
        send_byte(`DL_SND_START + 25'h1, rand_byte());
        send_byte(`DL_SCR_START - 25'h2, rand_byte());
        send_byte(`DL_SCR_START - 25'h1, rand_byte());
        wait_drain();
    endtask

    task automatic test_scroll();
        cur_test = "scroll";
        send_byte(`DL_SCR_START, rand_byte());
        send_byte(`DL_SCR_START + 25'h1, rand_byte());
        send_byte(`DL_SCR_START + 25'h2, rand_byte());
        send_byte(`DL_SCR_START + 25'h3, rand_byte());
        send_byte(`DL_SCR_START + 25'h1235, rand_byte());
        send_byte(`DL_SCR_START + 25'h2AAA, rand_byte());
        send_byte(`DL_OBJ_START - 25'h2, rand_byte());
        send_byte(`DL_OBJ_START - 25'h1, rand_byte());
        wait_drain();
    endtask

    // Every value of the five low word bits with alternating lanes
    task automatic test_object();
        cur_test = "object";
        for (int i = 0; i < 32; i++) begin
            send_byte(`DL_OBJ_START + 25'h800 + 25'(i * 2 + (i & 1)), rand_byte());
        end
        wait_drain();
    endtask

    task automatic test_prom();
        cur_test = "prom";
        send_byte(`DL_PROM_START, rand_byte());
        send_byte(`DL_PROM_START + 25'h1, rand_byte());
        send_byte(`DL_PROM_START + 25'h2AB, rand_byte());
        send_byte(`DL_END - 25'h1, rand_byte());
        wait_drain();
    endtask

    task automatic test_stream();
        logic [`DL_ADDR_W-1:0] addr;
        cur_test = "stream";
        for (int i = 0; i < 64; i++) begin
            // First byte always lies past the image
            addr = (i == 0) ? `DL_END + 25'h10 : random_addr();
            send_byte(addr, rand_byte());
        end
        wait_drain();
    endtask

    task automatic test_reset_idle();
        cur_test   = "reset_idle";
        // Bytes strobed during reset must never reach the write ports
        ioctl_wr   = 1'b1;
        ioctl_addr = 25'h000_0100;
        ioctl_dout = 8'hA5;
        rst        = 1'b1;
        repeat (16) begin
            @(posedge clk);
            #1;
            check_value("prog_we in reset", 32'd0, 32'(prog_we));
            check_value("prom_we in reset", 32'd0, 32'(prom_we));
        end
        rst      = 1'b0;
        ioctl_wr = 1'b0;
        repeat (32) begin
            @(posedge clk);
            #1;
            check_value("prog_we idle", 32'd0, 32'(prog_we));
            check_value("prom_we idle", 32'd0, 32'(prom_we));
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired, the run hung");
    end

    initial begin : main
        rst        = 1'b1;
        ioctl_wr   = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_main_sound();
        test_scroll();
        test_object();
        test_prom();
        test_stream();
        test_reset_idle();
        if (pending.size() != 0) begin
            abort_run("writes still outstanding at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+design
design/dl_pkg.sv
design/dl_region_decode.sv
design/dl_addr_scramble.sv
design/dl_write_port.sv
design/dl_postproc.sv
verif/dl_postproc_checker.sv
verif/dl_postproc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the download post-processor testbench with Verilator and runs it.
# The exit status is that of the simulation.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module dl_postproc_tb \
    -f sources.f \
    -o dl_postproc_sim

./obj_dir/dl_postproc_sim
